// ==== hw/cnn_pkg.sv ====
// Shared image geometry, data widths and filter constants, referenced by scoped name
package cnn_pkg;

    // Input image is square, one row per image_width pixels
    localparam int image_width = 28;
    localparam int kernel_size = 3;

    // Valid convolution rows per image
    localparam int conv_rows = image_width - kernel_size + 1;

    // Max pooling over pool_size x pool_size blocks
    localparam int pool_size = 2;
    localparam int pool_width = image_width / pool_size;

    // Pixel and weight widths, weights are unsigned fixed point
    localparam int value_bits = 8;
    localparam int weight_bits = 8;
    localparam int weight_q_shift = 6;
    localparam int product_bits = value_bits + weight_bits;

    // Counter widths
    localparam int col_bits = $clog2(image_width);
    localparam int row_bits = $clog2(image_width);
    localparam int pool_col_bits = $clog2(pool_width);

    // Box filter, 1/9 in Q2.6 rounded down
    localparam logic [weight_bits-1:0] kernel_weight =
        weight_bits'((1 << weight_q_shift) / (kernel_size * kernel_size));

endpackage

// ==== hw/row_if.sv ====
// Row handshake bundle between pipeline stages, instantiated once per stage boundary
`timescale 1ns/1ps

interface row_if #(
    parameter int row_len = 28,
    parameter int pixel_bits = 8
);

    logic [pixel_bits-1:0] row [row_len];
    logic                  valid;
    logic                  accept;
    // Marks the final row of an image
    logic                  last;

    // Producer holds row, valid and last until accept
    modport source (output row, output valid, output last, input accept);

    modport sink (input row, input valid, input last, output accept);

endinterface

// ==== hw/row_gatherer.sv ====
// Input stage that collects streamed pixels into rows and tags the last row of each image
`timescale 1ns/1ps

module row_gatherer (
    input  logic                             clock_i,
    input  logic                             reset_i,
    input  logic [cnn_pkg::value_bits-1:0]   in_data_i,
    input  logic                             in_valid_i,
    output logic                             upstream_stall_o,
    row_if.source                            row_o
);

    logic [cnn_pkg::image_width-1:0][cnn_pkg::value_bits-1:0] row_q;
    logic [cnn_pkg::col_bits-1:0] col_q;
    logic [cnn_pkg::row_bits-1:0] row_cnt_q;
    logic                         valid_q;
    logic                         last_q;
    logic                         take;

    // Input is held off for as long as a full row waits downstream
    assign upstream_stall_o = valid_q;
    assign take = in_valid_i && !valid_q;

    assign row_o.valid = valid_q;
    assign row_o.last = last_q;

    always_comb begin
        for (int c = 0; c < cnn_pkg::image_width; c++) begin
            row_o.row[c] = row_q[c];
        end
    end

    always_ff @(posedge clock_i) begin
        if (take) begin
            row_q[col_q] <= in_data_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            col_q <= '0;
            row_cnt_q <= '0;
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else if (take) begin
            if (int'(col_q) == cnn_pkg::image_width - 1) begin
                col_q <= '0;
                valid_q <= 1'b1;
                // Row count wraps so that images can follow back to back
                last_q <= (int'(row_cnt_q) == cnn_pkg::image_width - 1);
                if (int'(row_cnt_q) == cnn_pkg::image_width - 1) begin
                    row_cnt_q <= '0;
                end else begin
                    row_cnt_q <= row_cnt_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end else if (valid_q && row_o.accept) begin
            valid_q <= 1'b0;
        end
    end

    a_row_held: assert property (@(posedge clock_i) disable iff (reset_i)
        valid_q && !row_o.accept |=> valid_q && $stable(row_q) && $stable(last_q));

endmodule

// ==== hw/conv_line_buffer.sv ====
// Three-row shift buffer that exposes a 3x3 window and rotates its rows for the column sweep
`timescale 1ns/1ps

module conv_line_buffer (
    input  logic                           clock_i,
    input  logic [cnn_pkg::value_bits-1:0] next_row_i [cnn_pkg::image_width],
    input  logic                           shift_vert_i,
    input  logic                           shift_horiz_i,
    output logic [cnn_pkg::value_bits-1:0] window_o [cnn_pkg::kernel_size][cnn_pkg::kernel_size]
);

    // Row 0 holds the newest row
    logic [cnn_pkg::value_bits-1:0] line_q [cnn_pkg::kernel_size][cnn_pkg::image_width];

    always_ff @(posedge clock_i) begin
        if (shift_vert_i) begin
            line_q[0] <= next_row_i;
            for (int r = 1; r < cnn_pkg::kernel_size; r++) begin
                line_q[r] <= line_q[r-1];
            end
        end else if (shift_horiz_i) begin
            // Rotate left, column 0 wraps around to the far end
            for (int r = 0; r < cnn_pkg::kernel_size; r++) begin
                for (int c = 0; c < cnn_pkg::image_width - 1; c++) begin
                    line_q[r][c] <= line_q[r][c+1];
                end
                line_q[r][cnn_pkg::image_width-1] <= line_q[r][0];
            end
        end
    end

    // Window is always the leftmost kernel_size columns
    always_comb begin
        for (int r = 0; r < cnn_pkg::kernel_size; r++) begin
            for (int c = 0; c < cnn_pkg::kernel_size; c++) begin
                window_o[r][c] = line_q[r][c];
            end
        end
    end

endmodule

// ==== hw/conv_kernel.sv ====
// Registered 3x3 fixed-point weighted sum, result follows the window by one cycle
`timescale 1ns/1ps

module conv_kernel (
    input  logic                           clock_i,
    input  logic [cnn_pkg::value_bits-1:0] window_i [cnn_pkg::kernel_size][cnn_pkg::kernel_size],
    output logic [cnn_pkg::value_bits-1:0] sum_o
);

    logic [cnn_pkg::value_bits-1:0] sum_d;

    always_comb begin
        logic [cnn_pkg::product_bits-1:0] prod;
        prod = '0;
        sum_d = '0;
        for (int r = 0; r < cnn_pkg::kernel_size; r++) begin
            for (int c = 0; c < cnn_pkg::kernel_size; c++) begin
                prod = cnn_pkg::product_bits'(cnn_pkg::kernel_weight)
                     * cnn_pkg::product_bits'(window_i[r][c]);
                // Each tap is truncated before accumulation, max 27 per tap
                sum_d = sum_d + cnn_pkg::value_bits'(prod >> cnn_pkg::weight_q_shift);
            end
        end
    end

    always_ff @(posedge clock_i) begin
        sum_o <= sum_d;
    end

endmodule

// ==== hw/conv_layer.sv ====
// Convolution row controller that feeds the line buffer and collects one output row per input row
`timescale 1ns/1ps

module conv_layer (
    input  logic clock_i,
    input  logic reset_i,
    row_if.sink   in_row_i,
    row_if.source out_row_o
);

    typedef enum logic [1:0] {
        st_get_row,
        st_calc_wait,
        st_calc,
        st_wait_read
    } state_t;

    state_t                         state_q;
    logic [cnn_pkg::row_bits-1:0]   row_idx_q;
    logic [cnn_pkg::col_bits-1:0]   col_q;
    logic                           last_in_q;
    logic [cnn_pkg::value_bits-1:0] out_row_q [cnn_pkg::image_width];
    logic                           out_valid_q;
    logic                           out_last_q;
    logic                           shift_vert;
    logic                           shift_horiz;
    logic [cnn_pkg::value_bits-1:0] window [cnn_pkg::kernel_size][cnn_pkg::kernel_size];
    logic [cnn_pkg::value_bits-1:0] sum;

    conv_line_buffer line_buffer_inst (
        .clock_i       (clock_i),
        .next_row_i    (in_row_i.row),
        .shift_vert_i  (shift_vert),
        .shift_horiz_i (shift_horiz),
        .window_o      (window)
    );

    conv_kernel kernel_inst (
        .clock_i  (clock_i),
        .window_i (window),
        .sum_o    (sum)
    );

    // Row taken straight into the buffer on accept
    assign shift_vert = (state_q == st_get_row) && in_row_i.valid;
    assign shift_horiz = (state_q == st_calc);
    assign in_row_i.accept = shift_vert;

    assign out_row_o.row = out_row_q;
    assign out_row_o.valid = out_valid_q;
    assign out_row_o.last = out_last_q;

    // Kernel sum in st_calc belongs to the current column
    always_ff @(posedge clock_i) begin
        if (shift_horiz) begin
            out_row_q[col_q] <= sum;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= st_get_row;
            row_idx_q <= '0;
            col_q <= '0;
            last_in_q <= 1'b0;
            out_valid_q <= 1'b0;
            out_last_q <= 1'b0;
        end else begin
            case (state_q)
                st_get_row: begin
                    if (shift_vert) begin
                        row_idx_q <= in_row_i.last ? '0 : row_idx_q + 1'b1;
                        last_in_q <= in_row_i.last;
                        // First rows of an image only prime the buffer
                        if (int'(row_idx_q) >= cnn_pkg::image_width - cnn_pkg::conv_rows) begin
                            col_q <= '0;
                            state_q <= st_calc_wait;
                        end
                    end
                end
                st_calc_wait: begin
                    state_q <= st_calc;
                end
                st_calc: begin
                    col_q <= col_q + 1'b1;
                    if (int'(col_q) == cnn_pkg::image_width - 1) begin
                        out_valid_q <= 1'b1;
                        out_last_q <= last_in_q;
                        state_q <= st_wait_read;
                    end else begin
                        state_q <= st_calc_wait;
                    end
                end
                default: begin
                    if (out_row_o.accept) begin
                        out_valid_q <= 1'b0;
                        out_last_q <= 1'b0;
                        state_q <= st_get_row;
                    end
                end
            endcase
        end
    end

    a_no_shift_overlap: assert property (@(posedge clock_i) disable iff (reset_i)
        !(shift_vert && shift_horiz));

    // Gatherer and this controller must agree on image boundaries
    a_last_row_aligned: assert property (@(posedge clock_i) disable iff (reset_i)
        shift_vert && in_row_i.last |-> int'(row_idx_q) == cnn_pkg::image_width - 1);

endmodule

// ==== hw/max_pool_layer.sv ====
// Max pooling stage that folds pairs of convolved rows into one row of 2x2 maxima
`timescale 1ns/1ps

module max_pool_layer (
    input  logic clock_i,
    input  logic reset_i,
    row_if.sink   in_row_i,
    row_if.source out_row_o
);

    typedef enum logic [1:0] {
        st_get_row,
        st_calc_row,
        st_wait_read
    } state_t;

    state_t                                 state_q;
    logic [cnn_pkg::value_bits-1:0]         in_q [cnn_pkg::image_width];
    logic [cnn_pkg::value_bits-1:0]         max_q [cnn_pkg::pool_width];
    logic [cnn_pkg::pool_col_bits-1:0]      pos_q;
    logic [$clog2(cnn_pkg::pool_size)-1:0]  pair_q;
    logic                                   last_q;
    logic                                   take_row;
    logic                                   clear_max;
    logic [cnn_pkg::value_bits-1:0]         best_val;

    assign take_row = (state_q == st_get_row) && in_row_i.valid;
    assign clear_max = (state_q == st_wait_read) && out_row_o.accept;

    assign in_row_i.accept = take_row;
    assign out_row_o.row = max_q;
    assign out_row_o.valid = (state_q == st_wait_read);
    assign out_row_o.last = last_q;

    // Running maximum of one pooled column against its input columns
    always_comb begin
        logic [cnn_pkg::col_bits-1:0] idx;
        idx = '0;
        best_val = max_q[pos_q];
        for (int k = 0; k < cnn_pkg::pool_size; k++) begin
            idx = cnn_pkg::col_bits'(int'(pos_q) * cnn_pkg::pool_size + k);
            if (in_q[idx] > best_val) begin
                best_val = in_q[idx];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (take_row) begin
            in_q <= in_row_i.row;
        end
        if (reset_i || clear_max) begin
            for (int q = 0; q < cnn_pkg::pool_width; q++) begin
                max_q[q] <= '0;
            end
        end else if (state_q == st_calc_row) begin
            max_q[pos_q] <= best_val;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= st_get_row;
            pos_q <= '0;
            pair_q <= '0;
            last_q <= 1'b0;
        end else begin
            case (state_q)
                st_get_row: begin
                    if (take_row) begin
                        pos_q <= '0;
                        last_q <= in_row_i.last;
                        state_q <= st_calc_row;
                    end
                end
                st_calc_row: begin
                    pos_q <= pos_q + 1'b1;
                    if (int'(pos_q) == cnn_pkg::pool_width - 1) begin
                        pair_q <= pair_q + 1'b1;
                        if (int'(pair_q) == cnn_pkg::pool_size - 1 || last_q) begin
                            state_q <= st_wait_read;
                        end else begin
                            state_q <= st_get_row;
                        end
                    end
                end
                default: begin
                    if (clear_max) begin
                        pair_q <= '0;
                        state_q <= st_get_row;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/row_streamer.sv ====
// Output stage that serializes one pooled row at a time onto the stalling output stream
`timescale 1ns/1ps

module row_streamer (
    input  logic                           clock_i,
    input  logic                           reset_i,
    row_if.sink                            in_row_i,
    input  logic                           downstream_stall_i,
    output logic [cnn_pkg::value_bits-1:0] out_data_o,
    output logic                           out_valid_o,
    output logic                           out_last_o
);

    logic [cnn_pkg::value_bits-1:0]    row_q [cnn_pkg::pool_width];
    logic [cnn_pkg::pool_col_bits-1:0] idx_q;
    logic                              full_q;
    logic                              last_q;
    logic                              take_row;
    logic                              at_end;

    // A new row is taken only once the previous one is fully sent
    assign in_row_i.accept = !full_q;
    assign take_row = !full_q && in_row_i.valid;
    assign at_end = (int'(idx_q) == cnn_pkg::pool_width - 1);

    assign out_valid_o = full_q;
    assign out_data_o = row_q[idx_q];
    assign out_last_o = last_q && at_end;

    always_ff @(posedge clock_i) begin
        if (take_row) begin
            row_q <= in_row_i.row;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            idx_q <= '0;
            full_q <= 1'b0;
            last_q <= 1'b0;
        end else if (take_row) begin
            idx_q <= '0;
            full_q <= 1'b1;
            last_q <= in_row_i.last;
        end else if (full_q && !downstream_stall_i) begin
            idx_q <= at_end ? '0 : idx_q + 1'b1;
            full_q <= !at_end;
        end
    end

    a_hold_on_stall: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_o && downstream_stall_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_last_o));

endmodule

// ==== hw/cnn_top.sv ====
// Top level of the streaming 3x3 convolution and 2x2 max-pool filter with plain stream ports
`timescale 1ns/1ps

module cnn_top (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  logic [cnn_pkg::value_bits-1:0] in_data_i,
    input  logic                           in_valid_i,
    output logic                           upstream_stall_o,
    output logic [cnn_pkg::value_bits-1:0] out_data_o,
    output logic                           out_valid_o,
    output logic                           out_last_o,
    input  logic                           downstream_stall_i
);

    row_if #(.row_len(cnn_pkg::image_width), .pixel_bits(cnn_pkg::value_bits)) gathered_row ();
    row_if #(.row_len(cnn_pkg::image_width), .pixel_bits(cnn_pkg::value_bits)) conv_row ();
    row_if #(.row_len(cnn_pkg::pool_width), .pixel_bits(cnn_pkg::value_bits)) pooled_row ();

    row_gatherer row_gatherer_inst (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .upstream_stall_o (upstream_stall_o),
        .row_o            (gathered_row.source)
    );

    conv_layer conv_layer_inst (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .in_row_i  (gathered_row.sink),
        .out_row_o (conv_row.source)
    );

    max_pool_layer max_pool_layer_inst (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .in_row_i  (conv_row.sink),
        .out_row_o (pooled_row.source)
    );

    row_streamer row_streamer_inst (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .in_row_i           (pooled_row.sink),
        .downstream_stall_i (downstream_stall_i),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .out_last_o         (out_last_o)
    );

endmodule

// ==== tests/cnn_tb.sv ====
// Testbench for cnn_top, streams LFSR images and checks pooled outputs against a reference model
`timescale 1ns/1ps

module cnn_tb;

    localparam int pooled_rows = cnn_pkg::conv_rows / cnn_pkg::pool_size;
    localparam int values_per_image = pooled_rows * cnn_pkg::pool_width;
    localparam int num_images = 4;
    localparam int reset_cycles = 8;
    localparam int stall_limit = 2000;
    localparam int drain_limit = 40000;
    localparam int idle_cycles = 100;
    localparam logic [15:0] lfsr_seed = 16'd3903;

    logic                           clock_i = 1'b0;
    logic                           reset_i;
    logic [cnn_pkg::value_bits-1:0] in_data_i;
    logic                           in_valid_i;
    logic                           upstream_stall_o;
    logic [cnn_pkg::value_bits-1:0] out_data_o;
    logic                           out_valid_o;
    logic                           out_last_o;
    logic                           downstream_stall_i;

    // Current image and the expected pooled stream of every image sent so far
    logic [cnn_pkg::value_bits-1:0] img [cnn_pkg::image_width][cnn_pkg::image_width];
    logic [cnn_pkg::value_bits-1:0] exp_vals [num_images * values_per_image + 1];
    int                             exp_count = 0;
    int                             out_count;
    logic [cnn_pkg::value_bits-1:0] exp_data;
    logic                           exp_last;
    logic                           out_fire;
    logic [15:0]                    pix_lfsr = lfsr_seed;
    logic [15:0]                    stall_lfsr = lfsr_seed;
    logic                           stall_enable = 1'b0;
    string                          test_name = "reset";

    cnn_top cnn_top_inst (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .in_data_i          (in_data_i),
        .in_valid_i         (in_valid_i),
        .upstream_stall_o   (upstream_stall_o),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .out_last_o         (out_last_o),
        .downstream_stall_i (downstream_stall_i)
    );

    always #20 clock_i = ~clock_i;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_bits(input int count, output logic [15:0] value);
        value = '0;
        repeat (count) begin
            pix_lfsr = lfsr_next(pix_lfsr);
            value = {value[14:0], pix_lfsr[0]};
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic show_mismatch(input string check, input int expected, input int actual);
        fail_run($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                           test_name, check, expected, actual));
    endtask

    // Box filter with per-tap truncation, then 2x2 max over convolution rows and columns
    task automatic build_expected();
        int conv [cnn_pkg::conv_rows][cnn_pkg::image_width];
        int sum;
        int best;
        for (int r = 0; r < cnn_pkg::conv_rows; r++) begin
            for (int c = 0; c < cnn_pkg::image_width; c++) begin
                sum = 0;
                for (int i = 0; i < cnn_pkg::kernel_size; i++) begin
                    for (int j = 0; j < cnn_pkg::kernel_size; j++) begin
                        sum += (int'(cnn_pkg::kernel_weight)
                                * int'(img[r+i][(c+j) % cnn_pkg::image_width]))
                               >> cnn_pkg::weight_q_shift;
                    end
                end
                conv[r][c] = sum;
            end
        end
        for (int p = 0; p < pooled_rows; p++) begin
            for (int q = 0; q < cnn_pkg::pool_width; q++) begin
                best = 0;
                for (int dr = 0; dr < cnn_pkg::pool_size; dr++) begin
                    for (int dc = 0; dc < cnn_pkg::pool_size; dc++) begin
                        if (conv[p*2+dr][q*2+dc] > best) begin
                            best = conv[p*2+dr][q*2+dc];
                        end
                    end
                end
                exp_vals[exp_count] = cnn_pkg::value_bits'(best);
                exp_count++;
            end
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the pixel is taken
    task automatic send_pixel(input logic [cnn_pkg::value_bits-1:0] value, input bit with_gaps);
        logic [15:0] bits;
        int          waited;
        if (with_gaps) begin
            take_bits(2, bits);
            if (bits[1:0] == 2'b11) begin
                take_bits(2, bits);
                repeat (int'(bits[1:0]) + 1) @(negedge clock_i);
            end
        end
        in_data_i = value;
        in_valid_i = 1'b1;
        waited = 0;
        while (upstream_stall_o) begin
            @(negedge clock_i);
            waited++;
            if (waited > stall_limit) begin
                fail_run("Input side stayed stalled far longer than a row takes");
            end
        end
        @(negedge clock_i);
        in_valid_i = 1'b0;
    endtask

    task automatic send_image(input bit with_gaps);
        logic [15:0] bits;
        for (int r = 0; r < cnn_pkg::image_width; r++) begin
            for (int c = 0; c < cnn_pkg::image_width; c++) begin
                take_bits(cnn_pkg::value_bits, bits);
                img[r][c] = bits[cnn_pkg::value_bits-1:0];
            end
        end
        build_expected();
        for (int r = 0; r < cnn_pkg::image_width; r++) begin
            for (int c = 0; c < cnn_pkg::image_width; c++) begin
                send_pixel(img[r][c], with_gaps);
            end
        end
    endtask

    task automatic wait_for_outputs();
        int waited;
        waited = 0;
        while (out_count < exp_count) begin
            @(negedge clock_i);
            waited++;
            if (waited > drain_limit) begin
                fail_run("Output stream stopped before all expected values arrived");
            end
        end
    endtask

    // Random back-pressure on the output side
    always @(negedge clock_i) begin
        if (stall_enable) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            downstream_stall_i = stall_lfsr[0];
        end else begin
            downstream_stall_i = 1'b0;
        end
    end

    assign out_fire = out_valid_o && !downstream_stall_i;
    assign exp_data = exp_vals[out_count];
    assign exp_last = (out_count % values_per_image) == values_per_image - 1;

    always @(posedge clock_i) begin
        if (reset_i) begin
            out_count <= 0;
        end else if (out_fire) begin
            out_count <= out_count + 1;
        end
    end

    a_reset_valid_low: assert property (@(posedge clock_i) reset_i |=> !out_valid_o)
        else show_mismatch("out_valid_o after reset", 0, int'($sampled(out_valid_o)));

    a_reset_stall_low: assert property (@(posedge clock_i) reset_i |=> !upstream_stall_o)
        else show_mismatch("upstream_stall_o after reset", 0, int'($sampled(upstream_stall_o)));

    a_data_match: assert property (@(posedge clock_i) disable iff (reset_i)
        out_fire |-> out_data_o == exp_data)
        else show_mismatch($sformatf("out_data_o value %0d", $sampled(out_count)),
                           int'($sampled(exp_data)), int'($sampled(out_data_o)));

    // Last only on the final value of each image
    a_last_match: assert property (@(posedge clock_i) disable iff (reset_i)
        out_fire |-> out_last_o == exp_last)
        else show_mismatch($sformatf("out_last_o value %0d", $sampled(out_count)),
                           int'($sampled(exp_last)), int'($sampled(out_last_o)));

    a_no_extra_output: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_o |-> out_count < exp_count)
        else fail_run($sformatf("Output valid with no value left to expect in test %s",
                                test_name));

    a_hold_while_stalled: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_o && downstream_stall_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_last_o))
        else fail_run($sformatf("Output changed while stalled in test %s", test_name));

    initial begin
        reset_i = 1'b1;
        in_data_i = '0;
        in_valid_i = 1'b0;
        downstream_stall_i = 1'b0;
        repeat (reset_cycles) @(negedge clock_i);
        reset_i = 1'b0;
        @(negedge clock_i);

        test_name = "no_stall";
        send_image(1'b0);
        wait_for_outputs();

        test_name = "random_stall";
        stall_enable <= 1'b1;
        send_image(1'b0);
        wait_for_outputs();

        // Two images back to back with gaps on the input
        test_name = "gaps_back_to_back";
        send_image(1'b1);
        send_image(1'b1);
        wait_for_outputs();

        stall_enable <= 1'b0;
        repeat (idle_cycles) @(negedge clock_i);
        if (out_count == exp_count) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("Output count differs from the expected count at the end of the run");
        end
    end

endmodule

// ==== build.f ====
hw/cnn_pkg.sv
hw/row_if.sv
hw/row_gatherer.sv
hw/conv_line_buffer.sv
hw/conv_kernel.sv
hw/conv_layer.sv
hw/max_pool_layer.sv
hw/row_streamer.sv
hw/cnn_top.sv
tests/cnn_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --assert --timing -Wno-fatal
TOP       := cnn_tb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
